//--- Bender.yml
package:
  name: conv_fd

sources:
  - rtl/conv_pkg.sv
  - rtl/fetch_engine.sv
  - rtl/line_buffer.sv
  - rtl/exec_sequencer.sv
  - rtl/complex_mac_array.sv
  - rtl/store_engine.sv
  - rtl/conv_fd_top.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/host_mem_model.sv
      - tests/tb_conv_fd.sv

//--- rtl/complex_mac_array.sv
// Per-lane pipelined complex multiply and accumulate over the input maps of a group
module complex_mac_array (
  input  logic            clk,
  input  logic            reset,
  input  conv_pkg::line_t image_line,
  input  conv_pkg::line_t kernel_line,
  input  logic            mac_valid,
  input  logic            mac_last,
  output logic            res_valid,
  output conv_pkg::line_t res_line
);
  import conv_pkg::*;

  logic valid_s1;
  logic last_s1;
  // next accumulate starts a new group
  logic fresh;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
      last_s1 <= 1'b0;
      res_valid <= 1'b0;
      fresh <= 1'b1;
    end else begin
      valid_s1 <= mac_valid;
      last_s1 <= mac_valid && mac_last;
      res_valid <= valid_s1 && last_s1;
      if (valid_s1) begin
        fresh <= last_s1;
      end
    end
  end

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    comp_t ar;
    comp_t ai;
    comp_t br;
    comp_t bi;
    acc_t prod_re;
    acc_t prod_im;
    acc_t acc_re;
    acc_t acc_im;

    assign ar = image_line[2*COMP_W*k +: COMP_W];
    assign ai = image_line[2*COMP_W*k + COMP_W +: COMP_W];
    assign br = kernel_line[2*COMP_W*k +: COMP_W];
    assign bi = kernel_line[2*COMP_W*k + COMP_W +: COMP_W];

    always_ff @(posedge clk) begin
      // stage 1, complex product
      if (mac_valid) begin
        prod_re <= ar * br - ai * bi;
        prod_im <= ar * bi + ai * br;
      end
      // stage 2, accumulate
      if (valid_s1) begin
        acc_re <= (fresh ? acc_t'(0) : acc_re) + prod_re;
        acc_im <= (fresh ? acc_t'(0) : acc_im) + prod_im;
      end
    end

    assign res_line[2*COMP_W*k +: COMP_W] = acc_re[COMP_W-1:0];
    assign res_line[2*COMP_W*k + COMP_W +: COMP_W] = acc_im[COMP_W-1:0];
  end

endmodule

//--- rtl/conv_fd_top.sv
// Frequency-domain convolution core top level connecting fetch, buffers, MAC array and store
module conv_fd_top #(
  parameter int BANK_DEPTH_BITS = 4,
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  conv_pkg::addr_t  image_base,
  input  conv_pkg::addr_t  kernel_base,
  input  conv_pkg::addr_t  dest_base,
  input  conv_pkg::count_t num_in_maps,
  input  conv_pkg::count_t num_groups,
  output logic             rd_req_en,
  output conv_pkg::addr_t  rd_req_addr,
  output logic             rd_req_tag,
  input  logic             rd_req_almostfull,
  input  logic             rd_rsp_valid,
  input  logic             rd_rsp_tag,
  input  conv_pkg::line_t  rd_rsp_data,
  output logic             wr_req_en,
  output conv_pkg::addr_t  wr_req_addr,
  output conv_pkg::line_t  wr_req_data,
  input  logic             wr_req_almostfull,
  output logic             done
);
  import conv_pkg::*;

  logic image_free;
  logic kernel_free;
  logic image_ready;
  logic kernel_ready;
  logic buf_rd_en;
  logic [BANK_DEPTH_BITS-1:0] buf_rd_addr;
  logic bank_release;
  line_t image_line;
  line_t kernel_line;
  logic mac_valid;
  logic mac_last;
  logic res_valid;
  line_t res_line;
  logic space;

  fetch_engine u_fetch (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .image_base        (image_base),
    .kernel_base       (kernel_base),
    .num_in_maps       (num_in_maps),
    .num_groups        (num_groups),
    .rd_req_almostfull (rd_req_almostfull),
    .image_free        (image_free),
    .kernel_free       (kernel_free),
    .rd_req_en         (rd_req_en),
    .rd_req_addr       (rd_req_addr),
    .rd_req_tag        (rd_req_tag)
  );

  // both buffers see every response and keep only their own tag
  line_buffer #(
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS),
    .ACCEPT_TAG      (TAG_IMAGE)
  ) u_image_buf (
    .clk          (clk),
    .reset        (reset),
    .num_in_maps  (num_in_maps),
    .rsp_valid    (rd_rsp_valid),
    .rsp_tag      (rd_rsp_tag),
    .rsp_data     (rd_rsp_data),
    .rd_en        (buf_rd_en),
    .rd_addr      (buf_rd_addr),
    .bank_release (bank_release),
    .fill_free    (image_free),
    .ready        (image_ready),
    .rd_data      (image_line)
  );

  line_buffer #(
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS),
    .ACCEPT_TAG      (TAG_KERNEL)
  ) u_kernel_buf (
    .clk          (clk),
    .reset        (reset),
    .num_in_maps  (num_in_maps),
    .rsp_valid    (rd_rsp_valid),
    .rsp_tag      (rd_rsp_tag),
    .rsp_data     (rd_rsp_data),
    .rd_en        (buf_rd_en),
    .rd_addr      (buf_rd_addr),
    .bank_release (bank_release),
    .fill_free    (kernel_free),
    .ready        (kernel_ready),
    .rd_data      (kernel_line)
  );

  exec_sequencer #(
    .BANK_DEPTH_BITS (BANK_DEPTH_BITS)
  ) u_exec (
    .clk          (clk),
    .reset        (reset),
    .num_in_maps  (num_in_maps),
    .image_ready  (image_ready),
    .kernel_ready (kernel_ready),
    .space        (space),
    .rd_en        (buf_rd_en),
    .rd_addr      (buf_rd_addr),
    .bank_release (bank_release),
    .mac_valid    (mac_valid),
    .mac_last     (mac_last)
  );

  complex_mac_array u_mac (
    .clk         (clk),
    .reset       (reset),
    .image_line  (image_line),
    .kernel_line (kernel_line),
    .mac_valid   (mac_valid),
    .mac_last    (mac_last),
    .res_valid   (res_valid),
    .res_line    (res_line)
  );

  store_engine #(
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) u_store (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .dest_base         (dest_base),
    .num_groups        (num_groups),
    .res_valid         (res_valid),
    .res_line          (res_line),
    .wr_req_almostfull (wr_req_almostfull),
    .space             (space),
    .wr_req_en         (wr_req_en),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .done              (done)
  );

endmodule

//--- rtl/conv_pkg.sv
// Shared widths, line types and state encodings of the frequency-domain convolution core
package conv_pkg;

  // complex elements carried by one line
  localparam int LANES = 4;
  // width of one signed real or imaginary part
  localparam int COMP_W = 16;
  localparam int LINE_W = LANES * 2 * COMP_W;
  localparam int ACC_W = 40;

  // lane k: real part in the low half of slice k, imaginary part in the high half
  typedef logic [LINE_W-1:0] line_t;
  typedef logic signed [COMP_W-1:0] comp_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [31:0] addr_t;
  typedef logic [15:0] count_t;

  // per-bank status of the ping-pong tile buffers
  typedef enum logic [1:0] {VACANT, FILL, FULL, DRAIN} bank_state_t;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_IMAGE_WAIT,
    FETCH_IMAGE,
    FETCH_KERNEL_WAIT,
    FETCH_KERNEL,
    FETCH_DONE
  } fetch_state_t;

  typedef enum logic {EXEC_IDLE, EXEC_RUN} exec_state_t;

  // read tag values, image vs kernel
  localparam logic TAG_IMAGE = 1'b0;
  localparam logic TAG_KERNEL = 1'b1;

endpackage

//--- rtl/exec_sequencer.sv
// Execution sequencer pairing full image and kernel banks and streaming them into the MAC array
module exec_sequencer #(
  parameter int BANK_DEPTH_BITS = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_pkg::count_t           num_in_maps,
  input  logic                       image_ready,
  input  logic                       kernel_ready,
  input  logic                       space,
  output logic                       rd_en,
  output logic [BANK_DEPTH_BITS-1:0] rd_addr,
  output logic                       bank_release,
  output logic                       mac_valid,
  output logic                       mac_last
);
  import conv_pkg::*;

  exec_state_t state;
  logic [BANK_DEPTH_BITS-1:0] cnt;
  logic rd_last;

  assign rd_last = (count_t'(cnt) == num_in_maps - count_t'(1));
  assign rd_en = (state == EXEC_RUN);
  assign rd_addr = cnt;
  // both banks are handed back on the final read of the group
  assign bank_release = rd_en && rd_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXEC_IDLE;
      cnt <= '0;
      mac_valid <= 1'b0;
      mac_last <= 1'b0;
    end else begin
      // buffer read data arrives one cycle after the address
      mac_valid <= rd_en;
      mac_last <= bank_release;
      case (state)
        EXEC_IDLE: begin
          cnt <= '0;
          // space guards the results still in the pipeline
          if (image_ready && kernel_ready && space) begin
            state <= EXEC_RUN;
          end
        end
        EXEC_RUN: begin
          cnt <= cnt + 1'b1;
          if (rd_last) begin
            state <= EXEC_IDLE;
          end
        end
        default: begin
          state <= EXEC_IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/fetch_engine.sv
// Read request FSM issuing image then kernel line reads per group as buffer banks free up
module fetch_engine (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  conv_pkg::addr_t  image_base,
  input  conv_pkg::addr_t  kernel_base,
  input  conv_pkg::count_t num_in_maps,
  input  conv_pkg::count_t num_groups,
  input  logic             rd_req_almostfull,
  input  logic             image_free,
  input  logic             kernel_free,
  output logic             rd_req_en,
  output conv_pkg::addr_t  rd_req_addr,
  output logic             rd_req_tag
);
  import conv_pkg::*;

  fetch_state_t state;
  count_t group_cnt;
  count_t map_cnt;
  addr_t group_off;
  logic image_pend;
  logic kernel_pend;
  logic image_go;
  logic kernel_go;
  logic map_last;
  logic group_last;

  // the bank stays free until the first response of the group lands,
  // so a group only counts as done once free has dropped and come back
  assign image_go = image_free && !image_pend;
  assign kernel_go = kernel_free && !kernel_pend;
  assign map_last = (map_cnt == num_in_maps - count_t'(1));
  assign group_last = (group_cnt == num_groups - count_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      image_pend <= 1'b0;
      kernel_pend <= 1'b0;
    end else if (state == FETCH_IDLE) begin
      image_pend <= 1'b0;
      kernel_pend <= 1'b0;
    end else begin
      if (state == FETCH_IMAGE_WAIT && image_go) begin
        image_pend <= 1'b1;
      end else if (!image_free) begin
        image_pend <= 1'b0;
      end
      if (state == FETCH_KERNEL_WAIT && kernel_go) begin
        kernel_pend <= 1'b1;
      end else if (!kernel_free) begin
        kernel_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH_IDLE;
      rd_req_en <= 1'b0;
      group_cnt <= '0;
      map_cnt <= '0;
      group_off <= '0;
    end else begin
      rd_req_en <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          group_cnt <= '0;
          group_off <= '0;
          if (start) begin
            state <= FETCH_IMAGE_WAIT;
          end
        end
        FETCH_IMAGE_WAIT: begin
          map_cnt <= '0;
          if (image_go) begin
            state <= FETCH_IMAGE;
          end
        end
        FETCH_IMAGE: begin
          // almost-full stops the next request, the one already out is accepted
          if (!rd_req_almostfull) begin
            rd_req_en <= 1'b1;
            rd_req_addr <= image_base + group_off + addr_t'(map_cnt);
            rd_req_tag <= TAG_IMAGE;
            map_cnt <= map_cnt + count_t'(1);
            if (map_last) begin
              state <= FETCH_KERNEL_WAIT;
            end
          end
        end
        FETCH_KERNEL_WAIT: begin
          map_cnt <= '0;
          if (kernel_go) begin
            state <= FETCH_KERNEL;
          end
        end
        FETCH_KERNEL: begin
          if (!rd_req_almostfull) begin
            rd_req_en <= 1'b1;
            rd_req_addr <= kernel_base + group_off + addr_t'(map_cnt);
            rd_req_tag <= TAG_KERNEL;
            map_cnt <= map_cnt + count_t'(1);
            if (map_last) begin
              group_off <= group_off + addr_t'(num_in_maps);
              group_cnt <= group_cnt + count_t'(1);
              state <= group_last ? FETCH_DONE : FETCH_IMAGE_WAIT;
            end
          end
        end
        FETCH_DONE: begin
          if (!start) begin
            state <= FETCH_IDLE;
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/line_buffer.sv
// Two-bank ping-pong tile buffer filled from read responses and drained by the sequencer
module line_buffer #(
  parameter int   BANK_DEPTH_BITS = 4,
  parameter logic ACCEPT_TAG      = conv_pkg::TAG_IMAGE
) (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_pkg::count_t           num_in_maps,
  input  logic                       rsp_valid,
  input  logic                       rsp_tag,
  input  conv_pkg::line_t            rsp_data,
  input  logic                       rd_en,
  input  logic [BANK_DEPTH_BITS-1:0] rd_addr,
  input  logic                       bank_release,
  output logic                       fill_free,
  output logic                       ready,
  output conv_pkg::line_t            rd_data
);
  import conv_pkg::*;

  localparam int BANK_LINES = 2 ** BANK_DEPTH_BITS;

  line_t mem [0:2*BANK_LINES-1];
  bank_state_t bank_state [0:1];
  logic fill_ptr;
  logic drain_ptr;
  logic [BANK_DEPTH_BITS-1:0] fill_cnt;
  logic wr;
  logic wr_q;
  logic fill_last;

  assign wr = rsp_valid && (rsp_tag == ACCEPT_TAG);
  assign fill_last = (count_t'(fill_cnt) == num_in_maps - count_t'(1));

  // low for a cycle after each write, so every completed fill shows a gap
  assign fill_free = (bank_state[fill_ptr] == VACANT) && !wr_q;
  assign ready = (bank_state[drain_ptr] == FULL);

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[{fill_ptr, fill_cnt}] <= rsp_data;
    end
    rd_data <= mem[{drain_ptr, rd_addr}];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_ptr <= 1'b0;
      drain_ptr <= 1'b0;
      fill_cnt <= '0;
      wr_q <= 1'b0;
    end else begin
      wr_q <= wr;
      if (wr) begin
        fill_cnt <= fill_last ? '0 : fill_cnt + 1'b1;
        if (fill_last) begin
          fill_ptr <= ~fill_ptr;
        end
      end
      if (bank_release) begin
        drain_ptr <= ~drain_ptr;
      end
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_bank
    localparam logic BANK = 1'(b);

    always_ff @(posedge clk) begin
      if (reset) begin
        bank_state[b] <= VACANT;
      end else begin
        case (bank_state[b])
          VACANT: begin
            if (wr && fill_ptr == BANK) begin
              bank_state[b] <= fill_last ? FULL : FILL;
            end
          end
          FILL: begin
            if (wr && fill_ptr == BANK && fill_last) begin
              bank_state[b] <= FULL;
            end
          end
          FULL: begin
            // a single-line tile is released on its first read
            if (rd_en && drain_ptr == BANK) begin
              bank_state[b] <= bank_release ? VACANT : DRAIN;
            end
          end
          DRAIN: begin
            if (bank_release && drain_ptr == BANK) begin
              bank_state[b] <= VACANT;
            end
          end
          default: begin
            bank_state[b] <= VACANT;
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/store_engine.sv
// Output FIFO and write request issue with result addressing and the job done flag
module store_engine #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  conv_pkg::addr_t  dest_base,
  input  conv_pkg::count_t num_groups,
  input  logic             res_valid,
  input  conv_pkg::line_t  res_line,
  input  logic             wr_req_almostfull,
  output logic             space,
  output logic             wr_req_en,
  output conv_pkg::addr_t  wr_req_addr,
  output conv_pkg::line_t  wr_req_data,
  output logic             done
);
  import conv_pkg::*;

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;
  // at least three free entries
  localparam logic [FIFO_DEPTH_BITS:0] USED_MAX = (FIFO_DEPTH_BITS + 1)'(DEPTH - 3);

  line_t fifo_mem [0:DEPTH-1];
  logic [FIFO_DEPTH_BITS:0] wr_ptr;
  logic [FIFO_DEPTH_BITS:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0] used;
  logic empty;
  logic pop;
  count_t wr_cnt;

  assign used = wr_ptr - rd_ptr;
  assign empty = (used == '0);
  assign space = (used <= USED_MAX);
  assign pop = !empty && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (res_valid) begin
      fifo_mem[wr_ptr[FIFO_DEPTH_BITS-1:0]] <= res_line;
    end
    if (pop) begin
      wr_req_data <= fifo_mem[rd_ptr[FIFO_DEPTH_BITS-1:0]];
      wr_req_addr <= dest_base + addr_t'(wr_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      wr_req_en <= 1'b0;
      wr_cnt <= '0;
      done <= 1'b0;
    end else begin
      wr_req_en <= pop;
      if (res_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // results leave in group order, so the count doubles as the write offset
      if (!start) begin
        wr_cnt <= '0;
        done <= 1'b0;
      end else begin
        if (pop) begin
          wr_cnt <= wr_cnt + count_t'(1);
        end
        done <= (wr_cnt == num_groups);
      end
    end
  end

endmodule

//--- sources.f
rtl/conv_pkg.sv
rtl/fetch_engine.sv
rtl/line_buffer.sv
rtl/exec_sequencer.sv
rtl/complex_mac_array.sv
rtl/store_engine.sv
rtl/conv_fd_top.sv
tests/clk_gen.sv
tests/host_mem_model.sv
tests/tb_conv_fd.sv

//--- tests/clk_gen.sv
// Free-running testbench clock source
module clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

//--- tests/host_mem_model.sv
// Host memory model answering line reads in order after a random delay, with random almost-full
module host_mem_model (
  input  logic            clk,
  input  logic            reset,
  input  logic            rd_req_en,
  input  conv_pkg::addr_t rd_req_addr,
  input  logic            rd_req_tag,
  output logic            rd_req_almostfull,
  output logic            rd_rsp_valid,
  output logic            rd_rsp_tag,
  output conv_pkg::line_t rd_rsp_data,
  input  logic            wr_req_en,
  output logic            wr_req_almostfull,
  output int              rd_af_accepts,
  output int              wr_af_accepts
);
  import conv_pkg::*;

  localparam int MEM_LINES = 256;

  line_t mem [0:MEM_LINES-1];
  // outstanding reads, oldest first
  int unsigned due_q[$];
  logic tag_q[$];
  addr_t addr_q[$];
  int unsigned cycle;
  int unsigned last_due;
  // cycles left in the current write back-pressure burst
  int unsigned wr_af_left;

  initial begin
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_tag = 1'b0;
    rd_rsp_data = '0;
    rd_af_accepts = 0;
    wr_af_accepts = 0;
    cycle = 0;
    last_due = 0;
    wr_af_left = 0;
  end

  always @(posedge clk) begin : serve
    int unsigned due;
    addr_t head_addr;
    cycle = cycle + 1;
    if (reset) begin
      rd_req_almostfull <= 1'b0;
      wr_req_almostfull <= 1'b0;
      rd_rsp_valid <= 1'b0;
      rd_af_accepts <= 0;
      wr_af_accepts <= 0;
      wr_af_left = 0;
      due_q.delete();
      tag_q.delete();
      addr_q.delete();
    end else begin
      // read back-pressure on roughly one cycle in four
      rd_req_almostfull <= ($urandom_range(3) == 0);
      // write back-pressure comes in bursts long enough to back up the result FIFO
      if (wr_af_left > 0) begin
        wr_af_left = wr_af_left - 1;
        wr_req_almostfull <= 1'b1;
      end else if ($urandom_range(7) == 0) begin
        wr_af_left = 3 + $urandom_range(28);
        wr_req_almostfull <= 1'b1;
      end else begin
        wr_req_almostfull <= 1'b0;
      end
      // requests taken while almost-full was already up, per episode
      if (!rd_req_almostfull) begin
        rd_af_accepts <= 0;
      end else if (rd_req_en) begin
        rd_af_accepts <= rd_af_accepts + 1;
      end
      if (!wr_req_almostfull) begin
        wr_af_accepts <= 0;
      end else if (wr_req_en) begin
        wr_af_accepts <= wr_af_accepts + 1;
      end
      if (rd_req_en) begin
        due = cycle + 1 + $urandom_range(5);
        // keep responses in request order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        tag_q.push_back(rd_req_tag);
        addr_q.push_back(rd_req_addr);
      end
      rd_rsp_valid <= 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        head_addr = addr_q.pop_front();
        void'(due_q.pop_front());
        rd_rsp_valid <= 1'b1;
        rd_rsp_tag <= tag_q.pop_front();
        rd_rsp_data <= mem[head_addr[7:0]];
      end
    end
  end

endmodule

//--- tests/tb_conv_fd.sv
// Testbench for the frequency-domain convolution core with host memory and reference results
module tb_conv_fd;
  import conv_pkg::*;

  localparam int TIMEOUT = 6000;
  localparam int DONE_DROP_LIMIT = 20;
  localparam int MAX_GROUPS = 16;

  logic clk;
  logic reset;
  logic start;
  addr_t image_base;
  addr_t kernel_base;
  addr_t dest_base;
  count_t num_in_maps;
  count_t num_groups;
  logic rd_req_en;
  addr_t rd_req_addr;
  logic rd_req_tag;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  logic rd_rsp_tag;
  line_t rd_rsp_data;
  logic wr_req_en;
  addr_t wr_req_addr;
  line_t wr_req_data;
  logic wr_req_almostfull;
  logic done;
  int rd_af_accepts;
  int wr_af_accepts;

  int errors;
  int timeouts;
  logic started;
  logic job_clear;
  logic [255:0] rd_seen;
  int rd_cnt;
  count_t wr_idx;
  line_t exp_res [0:MAX_GROUPS-1];
  line_t exp_data;
  addr_t exp_addr;
  addr_t job_lines;
  logic img_hit;
  logic ker_hit;
  bit ok;

  clk_gen #(.PERIOD(40)) u_clk (.clk(clk));

  host_mem_model u_mem (
    .clk               (clk),
    .reset             (reset),
    .rd_req_en         (rd_req_en),
    .rd_req_addr       (rd_req_addr),
    .rd_req_tag        (rd_req_tag),
    .rd_req_almostfull (rd_req_almostfull),
    .rd_rsp_valid      (rd_rsp_valid),
    .rd_rsp_tag        (rd_rsp_tag),
    .rd_rsp_data       (rd_rsp_data),
    .wr_req_en         (wr_req_en),
    .wr_req_almostfull (wr_req_almostfull),
    .rd_af_accepts     (rd_af_accepts),
    .wr_af_accepts     (wr_af_accepts)
  );

  conv_fd_top #(
    .BANK_DEPTH_BITS (4),
    .FIFO_DEPTH_BITS (3)
  ) u_conv_fd_top (.*);

  assign job_lines = addr_t'(num_in_maps) * addr_t'(num_groups);
  assign img_hit = (rd_req_addr >= image_base) && (rd_req_addr < image_base + job_lines);
  assign ker_hit = (rd_req_addr >= kernel_base) && (rd_req_addr < kernel_base + job_lines);
  assign exp_data = exp_res[wr_idx[3:0]];
  assign exp_addr = dest_base + addr_t'(wr_idx);

  // per-job record of requested lines and written results
  always @(posedge clk) begin
    if (job_clear) begin
      rd_seen <= '0;
      rd_cnt <= 0;
      wr_idx <= '0;
    end else begin
      if (rd_req_en) begin
        rd_seen[rd_req_addr[7:0]] <= 1'b1;
        rd_cnt <= rd_cnt + 1;
      end
      if (wr_req_en) begin
        wr_idx <= wr_idx + count_t'(1);
      end
    end
  end

  idle_before_start: assert property (@(posedge clk) disable iff (reset)
      !started |-> !rd_req_en && !wr_req_en && !done)
    else begin
      errors++;
      $display("CHECK FAILED idle outputs rd_req_en %h wr_req_en %h done %h",
               $sampled(rd_req_en), $sampled(wr_req_en), $sampled(done));
    end

  read_in_range: assert property (@(posedge clk) disable iff (reset)
      rd_req_en |-> ((rd_req_tag == TAG_IMAGE) ? img_hit : ker_hit))
    else begin
      errors++;
      $display("read request outside the job's lines or with the wrong tag, addr %h tag %h",
               $sampled(rd_req_addr), $sampled(rd_req_tag));
    end

  read_once: assert property (@(posedge clk) disable iff (reset)
      rd_req_en |-> !rd_seen[rd_req_addr[7:0]])
    else begin
      errors++;
      $display("line %h was requested more than once", $sampled(rd_req_addr));
    end

  write_count: assert property (@(posedge clk) disable iff (reset)
      wr_req_en |-> wr_idx < num_groups)
    else begin
      errors++;
      $display("more write requests than groups in the job");
    end

  write_data: assert property (@(posedge clk) disable iff (reset)
      wr_req_en |-> wr_req_data == exp_data)
    else begin
      errors++;
      $display("CHECK FAILED wr_req_data group %h got %h expected %h",
               $sampled(wr_idx), $sampled(wr_req_data), $sampled(exp_data));
    end

  write_addr: assert property (@(posedge clk) disable iff (reset)
      wr_req_en |-> wr_req_addr == exp_addr)
    else begin
      errors++;
      $display("CHECK FAILED wr_req_addr got %h expected %h",
               $sampled(wr_req_addr), $sampled(exp_addr));
    end

  read_backpressure: assert property (@(posedge clk) disable iff (reset) rd_af_accepts <= 1)
    else begin
      errors++;
      $display("read port issued %0d requests in one almost-full episode",
               $sampled(rd_af_accepts));
    end

  write_backpressure: assert property (@(posedge clk) disable iff (reset) wr_af_accepts <= 1)
    else begin
      errors++;
      $display("write port issued %0d requests in one almost-full episode",
               $sampled(wr_af_accepts));
    end

  done_after_writes: assert property (@(posedge clk) disable iff (reset)
      done |-> wr_idx == num_groups)
    else begin
      errors++;
      $display("CHECK FAILED done with write count %h of %h", $sampled(wr_idx),
               $sampled(num_groups));
    end

  done_holds: assert property (@(posedge clk) disable iff (reset) done && start |=> done)
    else begin
      errors++;
      $display("done dropped while start was still high");
    end

  done_clears: assert property (@(posedge clk) disable iff (reset) !start |=> !done)
    else begin
      errors++;
      $display("done stayed high after start dropped");
    end

  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i] = {$urandom, $urandom, $urandom, $urandom};
    end
  endtask

  // per lane, sum of complex products over the input maps, low 16 bits of each part
  task automatic compute_expected(input addr_t img, input addr_t ker, input count_t n,
                                  input count_t g);
    line_t a;
    line_t b;
    addr_t off;
    int re;
    int im;
    int ar;
    int ai;
    int br;
    int bi;
    for (int grp = 0; grp < int'(g); grp++) begin
      for (int k = 0; k < LANES; k++) begin
        re = 0;
        im = 0;
        for (int i = 0; i < int'(n); i++) begin
          off = addr_t'(grp) * addr_t'(n) + addr_t'(i);
          a = u_mem.mem[8'(img + off)];
          b = u_mem.mem[8'(ker + off)];
          ar = $signed(a[2*COMP_W*k +: COMP_W]);
          ai = $signed(a[2*COMP_W*k + COMP_W +: COMP_W]);
          br = $signed(b[2*COMP_W*k +: COMP_W]);
          bi = $signed(b[2*COMP_W*k + COMP_W +: COMP_W]);
          re += ar * br - ai * bi;
          im += ar * bi + ai * br;
        end
        exp_res[grp][2*COMP_W*k +: COMP_W] = re[15:0];
        exp_res[grp][2*COMP_W*k + COMP_W +: COMP_W] = im[15:0];
      end
    end
  endtask

  task automatic run_job(input addr_t img, input addr_t ker, input addr_t dst,
                         input count_t n, input count_t g, output bit ok);
    int cycles;
    @(posedge clk);
    image_base <= img;
    kernel_base <= ker;
    dest_base <= dst;
    num_in_maps <= n;
    num_groups <= g;
    job_clear <= 1'b1;
    compute_expected(img, ker, n, g);
    @(posedge clk);
    job_clear <= 1'b0;
    start <= 1'b1;
    started <= 1'b1;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    ok = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout, done did not rise within %0d cycles", TIMEOUT);
    end else begin
      start <= 1'b0;
      cycles = 0;
      while (done && cycles < DONE_DROP_LIMIT) begin
        @(posedge clk);
        cycles++;
      end
      if (done) begin
        timeouts++;
        $display("timeout, done did not fall after start dropped");
      end else begin
        ok = 1'b1;
        assert (rd_cnt == 2 * int'(n) * int'(g))
          else begin
            errors++;
            $display("CHECK FAILED read request count got %h expected %h", rd_cnt,
                     2 * int'(n) * int'(g));
          end
        assert (wr_idx == g)
          else begin
            errors++;
            $display("CHECK FAILED write count got %h expected %h", wr_idx, g);
          end
      end
    end
  endtask

  initial begin
    void'($urandom(32'hae93_21c4));
    errors = 0;
    timeouts = 0;
    reset = 1'b1;
    start = 1'b0;
    image_base = '0;
    kernel_base = '0;
    dest_base = '0;
    num_in_maps = '0;
    num_groups = '0;
    started = 1'b0;
    job_clear = 1'b1;
    fill_memory();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // job A, short tiles
    run_job(32'h10, 32'h40, 32'h200, 16'd3, 16'd5, ok);
    // job B fills every bank to full depth
    if (ok) begin
      run_job(32'h60, 32'ha0, 32'h300, 16'd16, 16'd4, ok);
    end
    $display("run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
